// File: filelist.f
source/cache_be_pkg.sv
source/cache_read_channel.sv
source/cache_write_channel.sv
source/cache_be_arbiter.sv
source/cache_back_end.sv
tests/cache_be_props.sv
tests/cache_be_checker.sv
tests/tb_cache_back_end.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_back_end
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_cache_back_end.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cache_back_end;

   localparam int          WORD_OFFSET_W = 2;
   localparam int          LINE_LSB      = WORD_OFFSET_W + 2;
   localparam int          MEM_WORDS     = 1 << (cache_be_pkg::ADDR_W - 2);
   localparam logic [31:0] MEM_PATTERN   = 32'hA5C3_0F96;
   localparam int          ROWS          = 8;
   localparam int          ROW_CYCLES    = 300; // generous bound for one row under stalls.

   typedef struct packed {
      logic [1:0]  kind;      // bit 0 write, bit 1 fill.
      logic [15:0] addr;
      logic [31:0] data;
      logic [3:0]  strb;
      logic [3:0]  exp_words;
   } row_t;

   logic                  clk;
   logic                  rst_n;
   logic                  write_valid;
   cache_be_pkg::wr_req_t write_req;
   logic                  write_ready;
   logic                  replace_valid;
   logic [cache_be_pkg::ADDR_W-1:LINE_LSB] replace_addr;
   logic                  replace;
   logic                  read_valid;
   logic [WORD_OFFSET_W-1:0] read_addr;
   logic [31:0]           read_rdata;
   cache_be_pkg::be_req_t be_req;
   cache_be_pkg::be_rsp_t be_rsp;
   logic                  row_done;
   logic [3:0]            exp_words;
   int                    tests;
   int                    fails;
   int                    errors;
   int                    props_fails;
   row_t                  table_q [ROWS];
   logic [31:0]           mem [MEM_WORDS];
   logic [7:0]            lfsr_q;
   logic                  pend_rd;
   logic [1:0]            delay_q;
   logic [13:0]           pend_addr;

   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   cache_back_end #(.WORD_OFFSET_W(WORD_OFFSET_W)) dut0 (
      .clk_i(clk), .rst_n_i(rst_n), .write_valid_i(write_valid), .write_i(write_req),
      .write_ready_o(write_ready), .replace_valid_i(replace_valid),
      .replace_addr_i(replace_addr), .replace_o(replace), .read_valid_o(read_valid),
      .read_addr_o(read_addr), .read_rdata_o(read_rdata), .be_req_o(be_req), .be_rsp_i(be_rsp)
   );

   cache_be_checker #(.WORD_OFFSET_W(WORD_OFFSET_W), .MEM_PATTERN(MEM_PATTERN)) checker0 (
      .clk_i(clk), .rst_n_i(rst_n), .write_valid_i(write_valid), .write_i(write_req),
      .write_ready_i(write_ready), .replace_valid_i(replace_valid),
      .replace_addr_i(replace_addr), .replace_i(replace), .read_valid_i(read_valid),
      .read_addr_i(read_addr), .read_rdata_i(read_rdata), .be_req_i(be_req), .be_rsp_i(be_rsp),
      .row_done_i(row_done), .exp_words_i(exp_words), .tests_o(tests), .fails_o(fails),
      .errors_o(errors)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // memory responder with random ready stalls and rvalid delays.
   always @(posedge clk) begin
      logic [7:0] s;
      logic [3:0] bits;
      if (!rst_n) begin
         be_rsp  <= '0;
         lfsr_q  <= 8'd53;
         pend_rd <= 1'b0;
      end else begin
         s = lfsr_q;
         for (int k = 0; k < 4; k++) begin
            bits[k] = s[7];
            s = lfsr_step(s);
         end
         lfsr_q        <= s;
         be_rsp.rvalid <= 1'b0;
         if (pend_rd) begin
            if (delay_q == 2'd0) begin
               be_rsp.rvalid <= 1'b1;
               be_rsp.rdata  <= mem[pend_addr];
               pend_rd       <= 1'b0;
            end else begin
               delay_q <= delay_q - 2'd1;
            end
         end
         if (be_req.avalid && be_rsp.ready) begin
            if (be_req.wstrb == 4'b0000) begin
               pend_rd   <= 1'b1;
               pend_addr <= be_req.addr[15:2];
               delay_q   <= bits[3:2];
            end else begin
               for (int b = 0; b < 4; b++) begin
                  if (be_req.wstrb[b]) mem[be_req.addr[15:2]][8*b +: 8] <= be_req.wdata[8*b +: 8];
               end
            end
         end
         be_rsp.ready <= (bits[1:0] != 2'b00);
      end
   end

   initial begin
      #((8 + ROWS * ROW_CYCLES) * 40);
      $display("watchdog expired before all tests finished");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = 32'(i) ^ MEM_PATTERN;
      end
      table_q[0] = '{2'd2, 16'h0100, 32'h0,         4'h0, 4'd4};
      table_q[1] = '{2'd1, 16'h0104, 32'hDEADBEEF, 4'hF, 4'd0};
      table_q[2] = '{2'd1, 16'h0109, 32'h11223344, 4'h5, 4'd0}; // unaligned byte address.
      table_q[3] = '{2'd1, 16'h010E, 32'hAABBCCDD, 4'h8, 4'd0};
      table_q[4] = '{2'd2, 16'h0100, 32'h0,         4'h0, 4'd4};
      table_q[5] = '{2'd3, 16'h0204, 32'h55667788, 4'h3, 4'd4};
      table_q[6] = '{2'd3, 16'h0308, 32'h0F0F0F0F, 4'hF, 4'd4};
      table_q[7] = '{2'd2, 16'h3FF0, 32'h0,         4'h0, 4'd4};
      rst_n         = 1'b0;
      write_valid   = 1'b0;
      write_req     = '0;
      replace_valid = 1'b0;
      replace_addr  = '0;
      be_rsp        = '0;
      row_done      = 1'b0;
      exp_words     = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      for (int r = 0; r < ROWS; r++) begin
         @(posedge clk);
         if (table_q[r].kind[0]) begin
            write_valid <= 1'b1;
            write_req   <= '{table_q[r].addr, table_q[r].data, table_q[r].strb};
         end
         if (table_q[r].kind[1]) begin
            replace_valid <= 1'b1;
            replace_addr  <= table_q[r].addr[15:LINE_LSB];
         end
         @(posedge clk);
         write_valid   <= 1'b0;
         replace_valid <= 1'b0;
         do begin
            @(negedge clk);
         end while (!(write_ready && !replace));
         @(posedge clk);
         row_done  <= 1'b1;
         exp_words <= table_q[r].exp_words;
         @(posedge clk);
         row_done <= 1'b0;
      end
      repeat (2) @(posedge clk);
      props_fails = dut0.be_arb.props0.assert_fails;
      $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
               tests, fails, errors, props_fails);
      if (fails == 0 && errors == 0 && props_fails == 0 && tests == ROWS) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/cache_be_checker.sv
`timescale 1ns/10ps
`default_nettype none

module cache_be_checker #(
   parameter int          WORD_OFFSET_W = 2,
   parameter logic [31:0] MEM_PATTERN   = 32'h0
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  write_valid_i,
   input  cache_be_pkg::wr_req_t write_i,
   input  logic                  write_ready_i,
   input  logic                  replace_valid_i,
   input  logic [cache_be_pkg::ADDR_W-1:WORD_OFFSET_W+2] replace_addr_i,
   input  logic                  replace_i,
   input  logic                  read_valid_i,
   input  logic [WORD_OFFSET_W-1:0] read_addr_i,
   input  logic [31:0]           read_rdata_i,
   input  cache_be_pkg::be_req_t be_req_i,
   input  cache_be_pkg::be_rsp_t be_rsp_i,
   input  logic                  row_done_i,
   input  logic [3:0]            exp_words_i,
   output int                    tests_o,
   output int                    fails_o,
   output int                    errors_o
);

   localparam int MEM_WORDS = 1 << (cache_be_pkg::ADDR_W - 2);

   logic [31:0]                model [MEM_WORDS]; // memory as the front end should see it.
   cache_be_pkg::wr_req_t      wr_q [$];
   logic [cache_be_pkg::ADDR_W-1:WORD_OFFSET_W+2] line_q;
   logic [WORD_OFFSET_W-1:0]   ret_idx;
   logic [WORD_OFFSET_W-1:0]   bus_idx;
   int                         row_errs;
   int                         words;
   bit                         in_reset;

   task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      row_errs++;
      errors_o++;
   endtask

   task automatic fault(input string msg);
      $display("error at %0t: %s", $time, msg);
      row_errs++;
      errors_o++;
   endtask

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         model[i] = 32'(i) ^ MEM_PATTERN;
      end
      tests_o  = 0;
      fails_o  = 0;
      errors_o = 0;
      row_errs = 0;
      words    = 0;
      in_reset = 1'b0;
   end

   always @(posedge clk_i) begin
      cache_be_pkg::wr_req_t exp;
      logic [cache_be_pkg::ADDR_W-1:0] rd_addr;
      if (!rst_n_i) begin
         in_reset = 1'b1;
      end else begin
         if (in_reset) begin // first cycle out of reset.
            in_reset = 1'b0;
            if (!write_ready_i) mismatch("write_ready_o", 32'd1, 32'd0);
            if (replace_i) mismatch("replace_o", 32'd0, 32'd1);
            if (read_valid_i) mismatch("read_valid_o", 32'd0, 32'd1);
            if (be_req_i.avalid) mismatch("be_req_o.avalid", 32'd0, 32'd1);
         end
         if (replace_valid_i && !replace_i) begin
            line_q  = replace_addr_i;
            ret_idx = '0;
            bus_idx = '0;
         end
         // returned words are checked before a write in the same cycle changes memory.
         if (read_valid_i) begin
            if (!replace_i) fault("read_valid_o pulsed while replace_o was low");
            if (read_addr_i != ret_idx) mismatch("read_addr_o", 32'(ret_idx), 32'(read_addr_i));
            if (read_rdata_i != model[{line_q, ret_idx}]) begin
               mismatch("read_rdata_o", model[{line_q, ret_idx}], read_rdata_i);
            end
            ret_idx = ret_idx + 1'b1;
            words++;
         end
         if (write_valid_i && write_ready_i) begin
            exp.addr  = {write_i.addr[cache_be_pkg::ADDR_W-1:2], 2'b00};
            exp.wdata = write_i.wdata;
            exp.wstrb = write_i.wstrb;
            wr_q.push_back(exp);
         end
         if (be_req_i.avalid && be_rsp_i.ready) begin
            if (be_req_i.wstrb == 4'b0000) begin
               rd_addr = {line_q, bus_idx, 2'b00};
               if (be_req_i.addr != rd_addr) begin
                  mismatch("be_req_o.addr", 32'(rd_addr), 32'(be_req_i.addr));
               end
               bus_idx = bus_idx + 1'b1;
            end else if (wr_q.size() == 0) begin
               fault("a bus write appeared with no pending front-end write");
            end else begin
               exp = wr_q.pop_front();
               if (be_req_i.addr != exp.addr) begin
                  mismatch("be_req_o.addr", 32'(exp.addr), 32'(be_req_i.addr));
               end
               if (be_req_i.wdata != exp.wdata) begin
                  mismatch("be_req_o.wdata", exp.wdata, be_req_i.wdata);
               end
               if (be_req_i.wstrb != exp.wstrb) begin
                  mismatch("be_req_o.wstrb", 32'(exp.wstrb), 32'(be_req_i.wstrb));
               end
               for (int b = 0; b < 4; b++) begin
                  if (exp.wstrb[b]) begin
                     model[exp.addr[cache_be_pkg::ADDR_W-1:2]][8*b +: 8] = exp.wdata[8*b +: 8];
                  end
               end
            end
         end
         if (row_done_i) begin
            if (words != 32'(exp_words_i)) begin
               fault($sformatf("got %0d words, wanted %0d", words, exp_words_i));
            end
            if (wr_q.size() != 0) fault("a front-end write never reached the bus");
            if (row_errs == 0) begin
               $display("test %0d ok", tests_o);
            end else begin
               $display("test %0d failed with %0d errors", tests_o, row_errs);
               fails_o++;
            end
            tests_o++;
            row_errs = 0;
            words    = 0;
         end
      end
   end

endmodule

`default_nettype wire

// File: tests/cache_be_props.sv
`timescale 1ns/10ps
`default_nettype none

module cache_be_props (
   input logic                  clk_i,
   input logic                  rst_n_i,
   input cache_be_pkg::be_req_t wr_req_i,
   input cache_be_pkg::be_req_t be_req_i,
   input cache_be_pkg::be_rsp_t be_rsp_i,
   input logic [1:0]            be_ack_i
);

   int   assert_fails = 0;
   logic busy_q; // a bus transaction is accepted and not yet answered.
   logic wacc_q; // a write was accepted in the previous cycle.

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
         wacc_q <= 1'b0;
      end else begin
         wacc_q <= be_req_i.avalid && be_rsp_i.ready && (be_req_i.wstrb != '0);
         if (be_req_i.avalid && be_rsp_i.ready) begin
            busy_q <= 1'b1;
         end else if (be_rsp_i.rvalid || wacc_q) begin
            busy_q <= 1'b0;
         end
      end
   end

   req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (be_req_i.avalid && !be_rsp_i.ready) |=> $stable(be_req_i))
      else begin
         $error("bus request changed while stalled");
         assert_fails++;
      end

   write_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wr_req_i.avalid && !be_ack_i[1]) |=> $stable(wr_req_i))
      else begin
         $error("pending write changed before its acknowledge");
         assert_fails++;
      end

   one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      busy_q |-> !be_req_i.avalid)
      else begin
         $error("request issued while a transaction is outstanding");
         assert_fails++;
      end

endmodule

bind cache_be_arbiter cache_be_props props0 (
   .clk_i   (clk_i),
   .rst_n_i (rst_n_i),
   .wr_req_i(wr_req_i),
   .be_req_i(be_req_o),
   .be_rsp_i(be_rsp_i),
   .be_ack_i(be_ack_o)
);

`default_nettype wire

// File: source/cache_back_end.sv
`timescale 1ns/10ps
`default_nettype none

module cache_back_end #(
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic                            write_valid_i,
   input  cache_be_pkg::wr_req_t           write_i,
   output logic                            write_ready_o,
   input  logic                            replace_valid_i,
   input  logic [cache_be_pkg::ADDR_W-1:WORD_OFFSET_W+$clog2(cache_be_pkg::NBYTES)]
                                           replace_addr_i,
   output logic                            replace_o,
   output logic                            read_valid_o,
   output logic [WORD_OFFSET_W-1:0]        read_addr_o,
   output logic [cache_be_pkg::DATA_W-1:0] read_rdata_o,
   output cache_be_pkg::be_req_t           be_req_o,
   input  cache_be_pkg::be_rsp_t           be_rsp_i
);

   cache_be_pkg::be_req_t           rd_req;
   cache_be_pkg::be_req_t           wr_breq;
   logic [1:0]                      be_ack;
   logic [cache_be_pkg::DATA_W-1:0] be_rdata;

   cache_read_channel #(
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) read_fsm (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .replace_valid_i(replace_valid_i),
      .replace_addr_i (replace_addr_i),
      .replace_o      (replace_o),
      .read_valid_o   (read_valid_o),
      .read_addr_o    (read_addr_o),
      .read_rdata_o   (read_rdata_o),
      .be_req_o       (rd_req),
      .be_ack_i       (be_ack[0]),
      .be_rdata_i     (be_rdata)
   );

   cache_write_channel write_fsm (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .write_valid_i(write_valid_i),
      .write_i      (write_i),
      .write_ready_o(write_ready_o),
      .be_req_o     (wr_breq),
      .be_ack_i     (be_ack[1])
   );

   cache_be_arbiter be_arb (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .rd_req_i  (rd_req),
      .wr_req_i  (wr_breq),
      .be_rsp_i  (be_rsp_i),
      .be_req_o  (be_req_o),
      .be_ack_o  (be_ack),
      .be_rdata_o(be_rdata)
   );

endmodule

`default_nettype wire

// File: source/cache_be_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module cache_be_arbiter (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  cache_be_pkg::be_req_t           rd_req_i,
   input  cache_be_pkg::be_req_t           wr_req_i,
   input  cache_be_pkg::be_rsp_t           be_rsp_i,
   output cache_be_pkg::be_req_t           be_req_o,
   output logic [1:0]                      be_ack_o,   // bit 0 read channel, bit 1 write channel.
   output logic [cache_be_pkg::DATA_W-1:0] be_rdata_o
);

   logic lock_q;    // a transaction is accepted and not yet acknowledged.
   logic lock_rd_q; // owner of the stalled or locked grant.
   logic stall_q;   // the granted request waited for ready in the last cycle.
   logic wack_q;
   logic sel_rd;
   logic accept;
   logic wack;
   logic ack;

   // reads win a free grant and a stalled or locked grant stays with its owner.
   assign sel_rd = (lock_q | stall_q) ? lock_rd_q : rd_req_i.avalid;

   always_comb begin
      be_req_o        = sel_rd ? rd_req_i : wr_req_i;
      be_req_o.avalid = be_req_o.avalid & ~lock_q; // an outstanding request is not reissued.
   end

   assign accept = be_req_o.avalid & be_rsp_i.ready;
   assign wack   = accept & (be_req_o.wstrb != {cache_be_pkg::NBYTES{1'b0}});

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wack_q    <= 1'b0;
         lock_q    <= 1'b0;
         lock_rd_q <= 1'b0;
         stall_q   <= 1'b0;
      end else begin
         wack_q  <= wack;
         stall_q <= be_req_o.avalid & ~be_rsp_i.ready;
         if (be_req_o.avalid) begin
            lock_rd_q <= sel_rd;
         end
         if (ack) begin
            lock_q <= 1'b0;
         end else if (accept) begin
            lock_q <= 1'b1;
         end
      end
   end

   assign ack = be_rsp_i.rvalid | wack_q;

   // Steer the acknowledge to the channel that holds the grant, so a
   // request still waiting for the bus never sees the other one's ack.
   assign be_ack_o   = {ack & lock_q & ~lock_rd_q, ack & lock_q & lock_rd_q};
   assign be_rdata_o = be_rsp_i.rdata;

endmodule

`default_nettype wire

// File: source/cache_write_channel.sv
`timescale 1ns/10ps
`default_nettype none

module cache_write_channel (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  write_valid_i,
   input  cache_be_pkg::wr_req_t write_i,
   output logic                  write_ready_o,
   output cache_be_pkg::be_req_t be_req_o,
   input  logic                  be_ack_i
);

   localparam int BYTE_W = $clog2(cache_be_pkg::NBYTES);

   typedef enum logic {
      WR_IDLE,
      WR_WAIT
   } wr_state_t;

   wr_state_t             state_q;
   cache_be_pkg::wr_req_t hold_q;
   logic                  accept;

   assign accept = write_valid_i & write_ready_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= WR_IDLE;
      end else begin
         case (state_q)
            WR_IDLE: begin
               if (accept) begin
                  state_q <= WR_WAIT;
               end
            end
            default: begin
               if (be_ack_i) begin
                  state_q <= WR_IDLE;
               end
            end
         endcase
      end
   end

   // the stored write is held unchanged until memory acknowledges it.
   always_ff @(posedge clk_i) begin
      if (accept) begin
         hold_q.addr  <= {write_i.addr[cache_be_pkg::ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}};
         hold_q.wdata <= write_i.wdata;
         hold_q.wstrb <= write_i.wstrb;
      end
   end

   always_comb begin
      be_req_o.avalid = (state_q == WR_WAIT);
      be_req_o.addr   = hold_q.addr;
      be_req_o.wdata  = hold_q.wdata;
      be_req_o.wstrb  = hold_q.wstrb;
   end

   assign write_ready_o = (state_q == WR_IDLE);

endmodule

`default_nettype wire

// File: source/cache_read_channel.sv
`timescale 1ns/10ps
`default_nettype none

module cache_read_channel #(
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic                          replace_valid_i,
   input  logic [cache_be_pkg::ADDR_W-1:WORD_OFFSET_W+$clog2(cache_be_pkg::NBYTES)]
                                         replace_addr_i,
   output logic                          replace_o,
   output logic                          read_valid_o,
   output logic [WORD_OFFSET_W-1:0]      read_addr_o,
   output logic [cache_be_pkg::DATA_W-1:0] read_rdata_o,
   output cache_be_pkg::be_req_t         be_req_o,
   input  logic                          be_ack_i,
   input  logic [cache_be_pkg::DATA_W-1:0] be_rdata_i
);

   localparam int BYTE_W = $clog2(cache_be_pkg::NBYTES);
   localparam int LINE_W = cache_be_pkg::ADDR_W - WORD_OFFSET_W - BYTE_W;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_READ,
      RD_LAST
   } rd_state_t;

   rd_state_t                        state_q;
   logic      [LINE_W-1:0]           line_q;
   logic      [WORD_OFFSET_W-1:0]    word_q;
   logic                             valid_q;
   logic      [WORD_OFFSET_W-1:0]    idx_q;
   logic      [cache_be_pkg::DATA_W-1:0] rdata_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= RD_IDLE;
         valid_q <= 1'b0;
      end else begin
         valid_q <= 1'b0; // the word strobe lasts a single cycle.
         case (state_q)
            RD_IDLE: begin
               if (replace_valid_i) begin
                  state_q <= RD_READ;
               end
            end
            RD_READ: begin
               if (be_ack_i) begin
                  valid_q <= 1'b1;
                  if (&word_q) begin
                     state_q <= RD_LAST;
                  end
               end
            end
            default: begin
               state_q <= RD_IDLE; // busy drops after the last word is handed over.
            end
         endcase
      end
   end

   // line address, word counter and returned data.
   always_ff @(posedge clk_i) begin
      if (state_q == RD_IDLE && replace_valid_i) begin
         line_q <= replace_addr_i;
         word_q <= '0;
      end
      if (state_q == RD_READ && be_ack_i) begin
         rdata_q <= be_rdata_i;
         idx_q   <= word_q;
         word_q  <= word_q + 1'b1;
      end
   end

   always_comb begin
      be_req_o        = '0;
      be_req_o.avalid = (state_q == RD_READ);
      be_req_o.addr   = {line_q, word_q, {BYTE_W{1'b0}}};
   end

   assign replace_o    = (state_q != RD_IDLE);
   assign read_valid_o = valid_q;
   assign read_addr_o  = idx_q;
   assign read_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: source/cache_be_pkg.sv
`default_nettype none

package cache_be_pkg;

   // widths shared by the front end and the memory bus.
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int NBYTES = DATA_W / 8;

   // one request on the memory bus; an all-zero strobe marks a read.
   typedef struct packed {
      logic              avalid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } be_req_t;

   // response from the memory bus.
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid; // one-cycle pulse carrying read data.
      logic              ready;  // accepts the request presented in this cycle.
   } be_rsp_t;

   // one write coming from the cache front end.
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } wr_req_t;

endpackage

`default_nettype wire
